//--- design/alu_int.sv
`timescale 1ns/1ps

module alu_int
    import ex_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  ex_req_t req_i,
    input  dword_t  hilo_fwd_i,  // hi:lo with any pending write applied
    input  dword_t  product_i,
    output word_t   alu_word_o,
    output logic    ovf_o
);

    word_t logic_res;
    word_t shift_res;
    word_t arith_res;
    word_t move_res;
    word_t reg2_mux;   // reg2 or its two's complement
    word_t sum;
    logic  lt;

    // distance from the msb to the first set bit or 32 for zero
    function automatic logic [5:0] lead_count(word_t w);
        logic [5:0] n;
        logic       hit;
        n   = 6'd32;
        hit = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (w[i] && !hit) begin
                n   = 6'(31 - i);
                hit = 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        case (req_i.aluop)
            OP_OR:   logic_res = req_i.reg1 | req_i.reg2;
            OP_AND:  logic_res = req_i.reg1 & req_i.reg2;
            OP_NOR:  logic_res = ~(req_i.reg1 | req_i.reg2);
            OP_XOR:  logic_res = req_i.reg1 ^ req_i.reg2;
            default: logic_res = '0;
        endcase
    end

    // shift amount sits in reg1, value in reg2
    always_comb begin
        case (req_i.aluop)
            OP_SLL:  shift_res = req_i.reg2 << req_i.reg1[4:0];
            OP_SRL:  shift_res = req_i.reg2 >> req_i.reg1[4:0];
            OP_SRA:  shift_res = word_t'($signed(req_i.reg2) >>> req_i.reg1[4:0]);
            default: shift_res = '0;
        endcase
    end

    assign reg2_mux = is_neg_op(req_i.aluop) ? -req_i.reg2 : req_i.reg2;
    assign sum      = req_i.reg1 + reg2_mux;

    // operands of the same effective sign with a flipped result sign
    assign ovf_o = is_ovf_op(req_i.aluop) &&
                   (req_i.reg1[31] == (req_i.reg2[31] ^ is_neg_op(req_i.aluop))) &&
                   (sum[31] != req_i.reg1[31]);

    // signed compare from the signs and the difference
    assign lt = (req_i.aluop == OP_SLT) ?
                ((req_i.reg1[31] && !req_i.reg2[31]) ||
                 (!req_i.reg1[31] && !req_i.reg2[31] && sum[31]) ||
                 (req_i.reg1[31] && req_i.reg2[31] && sum[31])) :
                (req_i.reg1 < req_i.reg2);

    always_comb begin
        case (req_i.aluop)
            OP_SLT, OP_SLTU: arith_res = {31'd0, lt};
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_SUB, OP_SUBU: arith_res = sum;
            OP_CLZ:          arith_res = {26'd0, lead_count(req_i.reg1)};
            OP_CLO:          arith_res = {26'd0, lead_count(~req_i.reg1)};
            default:         arith_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.aluop)
            OP_MFHI:         move_res = hilo_fwd_i[63:32];
            OP_MFLO:         move_res = hilo_fwd_i[31:0];
            OP_MOVZ, OP_MOVN: move_res = req_i.reg1; // condition handled in decode
            default:         move_res = '0;
        endcase
    end

    always_comb begin
        case (req_i.alusel)
            SEL_LOGIC: alu_word_o = logic_res;
            SEL_SHIFT: alu_word_o = shift_res;
            SEL_ARITH: alu_word_o = arith_res;
            SEL_MOVE:  alu_word_o = move_res;
            SEL_MUL:   alu_word_o = product_i[31:0]; // mul keeps the low word
            default:   alu_word_o = '0;
        endcase
    end

    // decode always hands over a defined result class
    always_comb begin
        assert final (!$isunknown(req_i.alusel))
            else $error("alu_int: alusel unknown");
    end

endmodule

//--- design/ex_commit.sv
`timescale 1ns/1ps

module ex_commit
    import ex_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  ex_req_t    req_i,
    input  logic       stall_i,
    input  word_t      alu_word_i,
    input  logic       ovf_i,
    input  dword_t     product_i,
    input  dword_t     acc_sum_i,
    input  logic       acc_done_i,
    input  dword_t     hilo_fwd_i,
    output ex_result_t result_o,
    output hilo_wr_t   pend_o
);

    ex_result_t res_d;
    hilo_wr_t   pend_d;

    always_comb begin
        res_d.wd    = req_i.wd;
        res_d.wreg  = req_i.wreg && !ovf_i; // overflow kills the write
        res_d.wdata = alu_word_i;

        pend_d = '0;
        if (is_mult_hilo(req_i.aluop)) begin
            pend_d = {1'b1, product_i};
        end else if (acc_done_i) begin
            pend_d = {1'b1, acc_sum_i};
        end else if (req_i.aluop == OP_MTHI) begin
            pend_d = {1'b1, req_i.reg1, hilo_fwd_i[31:0]};  // lo kept
        end else if (req_i.aluop == OP_MTLO) begin
            pend_d = {1'b1, hilo_fwd_i[63:32], req_i.reg1}; // hi kept
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o <= '0;
            pend_o   <= '0;
        end else if (stall_i) begin
            result_o <= '0; // bubble
            pend_o   <= '0;
        end else begin
            result_o <= res_d;
            pend_o   <= pend_d;
        end
    end

    // hi/lo writers never target the register file
    assert property (@(posedge clk) disable iff (!arst_n_i) pend_o.we |-> !result_o.wreg)
        else $error("ex_commit: hi/lo write together with a register write");

endmodule

//--- design/ex_isa_pkg.sv
package ex_isa_pkg;

    // one operation code per instruction
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_MOVZ  = 8'b0000_1010,
        OP_MOVN  = 8'b0000_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        OP_SLL   = 8'b0111_1100,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MUL   = 8'b1010_1001,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001
    } aluop_e;

    // result class picking the datapath that drives the write word
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100,
        SEL_MUL   = 3'b101
    } alusel_e;

    // second operand enters the adder negated
    function automatic logic is_neg_op(aluop_e op);
        return op inside {OP_SUB, OP_SUBU, OP_SLT};
    endfunction

    function automatic logic is_ovf_op(aluop_e op);
        return op inside {OP_ADD, OP_ADDI, OP_SUB}; // trap on signed overflow
    endfunction

    function automatic logic is_signed_mul(aluop_e op);
        return op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
    endfunction

    function automatic logic is_macc(aluop_e op);
        return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

    function automatic logic is_msub(aluop_e op);
        return op inside {OP_MSUB, OP_MSUBU};
    endfunction

    // plain multiplies that land the product straight in hi:lo
    function automatic logic is_mult_hilo(aluop_e op);
        return op inside {OP_MULT, OP_MULTU};
    endfunction

endpackage

//--- design/ex_top.sv
`timescale 1ns/1ps

module ex_top
    import ex_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  ex_req_t    req_i,
    output logic       stall_o,
    output ex_result_t result_o
);

    dword_t   hilo_fwd;
    dword_t   product;
    dword_t   acc_sum;
    logic     acc_done;
    word_t    alu_word;
    logic     ovf;
    hilo_wr_t pend;       // hi/lo write one edge old

    alu_int u_alu_int (
        .req_i      (req_i),
        .hilo_fwd_i (hilo_fwd),
        .product_i  (product),
        .alu_word_o (alu_word),
        .ovf_o      (ovf)
    );

    mul_acc u_mul_acc (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .hilo_fwd_i (hilo_fwd),
        .product_o  (product),
        .acc_sum_o  (acc_sum),
        .acc_done_o (acc_done),
        .stall_o    (stall_o)
    );

    hilo_file u_hilo_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pend_i     (pend),
        .hilo_fwd_o (hilo_fwd)
    );

    ex_commit u_ex_commit (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .stall_i    (stall_o),
        .alu_word_i (alu_word),
        .ovf_i      (ovf),
        .product_i  (product),
        .acc_sum_i  (acc_sum),
        .acc_done_i (acc_done),
        .hilo_fwd_i (hilo_fwd),
        .result_o   (result_o),
        .pend_o     (pend)
    );

endmodule

//--- design/ex_types_pkg.sv
package ex_types_pkg;

    import ex_isa_pkg::*;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;    // hi in the upper half
    typedef logic [4:0]  reg_addr_t;

    // decoded instruction as handed over by the decode stage
    typedef struct packed {
        aluop_e    aluop;
        alusel_e   alusel;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;     // destination register
        logic      wreg;   // destination write wanted
    } ex_req_t;

    // register file write leaving the stage
    typedef struct packed {
        reg_addr_t wd;
        logic      wreg;
        word_t     wdata;
    } ex_result_t;

    // hi/lo write either requested or pending
    typedef struct packed {
        logic  we;
        word_t hi;
        word_t lo;
    } hilo_wr_t;

endpackage

//--- design/hilo_file.sv
`timescale 1ns/1ps

module hilo_file
    import ex_types_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  hilo_wr_t pend_i,      // write committed on the last edge
    output dword_t   hilo_fwd_o
);

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (pend_i.we) begin
            hi_q <= pend_i.hi;
            lo_q <= pend_i.lo;
        end
    end

    // pending value wins until it lands
    assign hilo_fwd_o = pend_i.we ? {pend_i.hi, pend_i.lo} : {hi_q, lo_q};

endmodule

//--- design/mul_acc.sv
`timescale 1ns/1ps

module mul_acc
    import ex_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n_i,
    input  ex_req_t req_i,
    input  dword_t  hilo_fwd_i,
    output dword_t  product_o,
    output dword_t  acc_sum_o,
    output logic    acc_done_o,
    output logic    stall_o
);

    typedef enum logic {
        IDLE,
        ACCUM
    } acc_state_e;

    acc_state_e state_q;
    acc_state_e state_d;
    logic       sgn;
    word_t      op1;
    word_t      op2;
    dword_t     mag;        // unsigned product of the magnitudes
    dword_t     partial_q;  // product negated for msub

    assign sgn = is_signed_mul(req_i.aluop);
    assign op1 = (sgn && req_i.reg1[31]) ? -req_i.reg1 : req_i.reg1;
    assign op2 = (sgn && req_i.reg2[31]) ? -req_i.reg2 : req_i.reg2;
    assign mag = {32'd0, op1} * {32'd0, op2};

    // operand signs differ, so the signed product is negative
    assign product_o = (sgn && (req_i.reg1[31] ^ req_i.reg2[31])) ? -mag : mag;

    assign stall_o    = (state_q == IDLE) && is_macc(req_i.aluop);
    assign acc_done_o = (state_q == ACCUM);
    assign acc_sum_o  = partial_q + hilo_fwd_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (stall_o) begin
                    state_d = ACCUM;
                end
            end
            ACCUM: begin
                state_d = IDLE; // accumulate commits on this edge
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_o) begin
            partial_q <= is_msub(req_i.aluop) ? -product_o : product_o;
        end
    end

    // a stalled madd/msub must stay on the inputs for its second look
    assert property (@(posedge clk) disable iff (!arst_n_i) stall_o |=> $stable(req_i))
        else $error("mul_acc: request changed while stalled");

endmodule

//--- flist.f
design/ex_isa_pkg.sv
design/ex_types_pkg.sv
design/alu_int.sv
design/mul_acc.sv
design/hilo_file.sv
design/ex_commit.sv
design/ex_top.sv
test/ex_checker.sv
test/tb_ex_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f flist.f --top-module tb_ex_top \
    && ./obj_dir/Vtb_ex_top | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/ex_checker.sv
`timescale 1ns/1ps

module ex_checker
    import ex_isa_pkg::*;
    import ex_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  ex_req_t    req_i,
    input  logic       stall_i,
    input  ex_result_t result_i,
    output int         val_err_o,
    output int         stall_err_o,
    output int         checks_o
);

    dword_t     hilo_m     = '0;   // hi:lo as the next instruction sees it
    logic       acc_phase  = 1'b0; // madd/msub on its second look
    logic       armed      = 1'b0;
    ex_result_t exp_res    = '0;
    int         val_errs   = 0;
    int         stall_errs = 0;
    int         checks     = 0;

    assign val_err_o   = val_errs;
    assign stall_err_o = stall_errs;
    assign checks_o    = checks;

    // run of bits equal to b counted from the msb
    function automatic word_t count_lead(word_t w, logic b);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == b) begin
            n++;
        end
        return word_t'(n);
    endfunction

    function automatic dword_t mul_full(word_t x, word_t y, logic sgn);
        longint a;
        longint b;
        if (sgn) begin
            a = longint'($signed(x));
            b = longint'($signed(y));
        end else begin
            a = longint'({32'd0, x});
            b = longint'({32'd0, y});
        end
        return dword_t'(a * b);
    endfunction

    // logical shift with the vacated top bits set to the sign
    function automatic word_t shift_right_arith(word_t v, int sh);
        word_t fill;
        fill = v[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
        return (v >> sh) | fill;
    endfunction

    function automatic logic fits_word(longint s);
        return s == longint'($signed(s[31:0]));
    endfunction

    task automatic compare_field(string name, word_t want, word_t got);
        if (want !== got) begin
            $display("FAILED %0t %s exp %h got %h", $time, name, want, got);
            val_errs++;
        end
    endtask

    always @(posedge clk or negedge arst_n_i) begin : model
        ex_result_t e;
        dword_t     ps;
        dword_t     pu;
        longint     s;
        logic       stall_exp;
        if (!arst_n_i) begin
            hilo_m    = '0;
            acc_phase = 1'b0;
            exp_res   = '0;
            armed     = 1'b0;
        end else begin
            stall_exp = !acc_phase &&
                        (req_i.aluop inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU});
            if (stall_i !== stall_exp) begin
                $display("FAILED %0t stall_o exp %b got %b", $time, stall_exp, stall_i);
                stall_errs++;
            end
            ps = mul_full(req_i.reg1, req_i.reg2, 1'b1);
            pu = mul_full(req_i.reg1, req_i.reg2, 1'b0);
            e  = '0;
            if (stall_exp) begin
                acc_phase = 1'b1; // bubble goes out
            end else begin
                acc_phase = 1'b0;
                e.wd      = req_i.wd;
                e.wreg    = req_i.wreg;
                case (req_i.aluop)
                    OP_OR:   e.wdata = req_i.reg1 | req_i.reg2;
                    OP_AND:  e.wdata = req_i.reg1 & req_i.reg2;
                    OP_NOR:  e.wdata = ~(req_i.reg1 | req_i.reg2);
                    OP_XOR:  e.wdata = req_i.reg1 ^ req_i.reg2;
                    OP_SLL:  e.wdata = req_i.reg2 << req_i.reg1[4:0];
                    OP_SRL:  e.wdata = req_i.reg2 >> req_i.reg1[4:0];
                    OP_SRA:  e.wdata = shift_right_arith(req_i.reg2, int'(req_i.reg1[4:0]));
                    OP_ADD, OP_ADDI: begin
                        s       = longint'($signed(req_i.reg1)) + longint'($signed(req_i.reg2));
                        e.wdata = s[31:0];
                        e.wreg  = req_i.wreg && fits_word(s);
                    end
                    OP_SUB: begin
                        s       = longint'($signed(req_i.reg1)) - longint'($signed(req_i.reg2));
                        e.wdata = s[31:0];
                        e.wreg  = req_i.wreg && fits_word(s);
                    end
                    OP_ADDU, OP_ADDIU: e.wdata = req_i.reg1 + req_i.reg2;
                    OP_SUBU: e.wdata = req_i.reg1 - req_i.reg2;
                    OP_SLT:  e.wdata = {31'd0, $signed(req_i.reg1) < $signed(req_i.reg2)};
                    OP_SLTU: e.wdata = {31'd0, req_i.reg1 < req_i.reg2};
                    OP_CLZ:  e.wdata = count_lead(req_i.reg1, 1'b0);
                    OP_CLO:  e.wdata = count_lead(req_i.reg1, 1'b1);
                    OP_MFHI: e.wdata = hilo_m[63:32];
                    OP_MFLO: e.wdata = hilo_m[31:0];
                    OP_MOVZ, OP_MOVN: e.wdata = req_i.reg1;
                    OP_MUL:   e.wdata = ps[31:0];
                    OP_MULT:  hilo_m = ps;
                    OP_MULTU: hilo_m = pu;
                    OP_MADD:  hilo_m = hilo_m + ps;
                    OP_MADDU: hilo_m = hilo_m + pu;
                    OP_MSUB:  hilo_m = hilo_m - ps;
                    OP_MSUBU: hilo_m = hilo_m - pu;
                    OP_MTHI:  hilo_m[63:32] = req_i.reg1;
                    OP_MTLO:  hilo_m[31:0] = req_i.reg1;
                    default: ;
                endcase
            end
            exp_res = e;
            armed   = 1'b1;
            checks++;
        end
    end

    // result_o settles after the rising edge, so look half a period later
    always @(negedge clk) begin
        if (!arst_n_i) begin
            compare_field("result_o.wreg", 32'd0, word_t'(result_i.wreg)); // cleared by reset
            compare_field("stall_o", 32'd0, word_t'(stall_i));
        end else if (armed) begin
            compare_field("result_o.wd", word_t'(exp_res.wd), word_t'(result_i.wd));
            compare_field("result_o.wreg", word_t'(exp_res.wreg), word_t'(result_i.wreg));
            compare_field("result_o.wdata", exp_res.wdata, result_i.wdata);
        end
    end

endmodule

//--- test/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top
    import ex_isa_pkg::*;
    import ex_types_pkg::*;
();

    localparam int NUM_INSTR   = 2000;
    localparam int STALL_LIMIT = 8;

    logic       clk;
    logic       arst_n_i;
    ex_req_t    req;
    logic       stall;
    ex_result_t result;
    int         seed;
    logic       hung;
    aluop_e     last_op;
    int         val_errs;
    int         stall_errs;
    int         checks;

    aluop_e op_list [31] = '{
        OP_NOP, OP_SRL, OP_SRA, OP_MOVZ, OP_MOVN, OP_MFHI, OP_MTHI, OP_MFLO,
        OP_MTLO, OP_MULT, OP_MULTU, OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND,
        OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU, OP_ADDI, OP_ADDIU, OP_SLL,
        OP_MADD, OP_MADDU, OP_MUL, OP_MSUB, OP_MSUBU, OP_CLZ, OP_CLO
    };

    ex_top u_ex_top (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (req),
        .stall_o  (stall),
        .result_o (result)
    );

    ex_checker u_checker (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .stall_i     (stall),
        .result_i    (result),
        .val_err_o   (val_errs),
        .stall_err_o (stall_errs),
        .checks_o    (checks)
    );

    always #10 clk = ~clk;

    function automatic alusel_e class_of(aluop_e op);
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: return SEL_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        return SEL_SHIFT;
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return SEL_ARITH;
            OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN: return SEL_MOVE;
            OP_MUL:  return SEL_MUL;
            default: return SEL_NOP; // hi/lo writers and nop
        endcase
    endfunction

    function automatic logic hilo_writer(aluop_e op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU,
                          OP_MSUB, OP_MSUBU, OP_MTHI, OP_MTLO};
    endfunction

    function automatic ex_req_t random_req();
        ex_req_t r;
        aluop_e  op;
        int      idx;
        int      k;
        idx = $unsigned($random(seed)) % 31;
        op  = op_list[idx];
        // read hi/lo straight after a write half of the time
        if (hilo_writer(last_op) && ($unsigned($random(seed)) % 2 == 0)) begin
            op = ($unsigned($random(seed)) % 2 == 0) ? OP_MFHI : OP_MFLO;
        end
        r.aluop  = op;
        r.alusel = class_of(op);
        r.reg1   = $random(seed);
        r.reg2   = $random(seed);
        if ($unsigned($random(seed)) % 16 == 0) begin
            r.reg2 = 32'h8000_0000; // most negative word for the sub overflow corner
        end
        k        = $unsigned($random(seed)) % 32;
        if (op == OP_CLZ) begin
            r.reg1 = r.reg1 >> k;    // spread the count
        end else if (op == OP_CLO) begin
            r.reg1 = ~(r.reg1 >> k);
        end
        r.wd   = reg_addr_t'($random(seed));
        r.wreg = !hilo_writer(op) && (op != OP_NOP) && ($unsigned($random(seed)) % 4 != 0);
        return r;
    endfunction

    // drive on the falling edge and hold until an edge with stall_o low
    task automatic issue(input ex_req_t r);
        int waited;
        waited = 0;
        @(negedge clk);
        req = r;
        #1; // stall_o has settled well before the rising edge
        while (stall && waited < STALL_LIMIT) begin
            waited++;
            @(negedge clk);
            #1;
        end
        if (stall) begin
            $display("timeout: stall_o stayed high for %0d cycles, instruction not accepted",
                     STALL_LIMIT);
            hung = 1'b1;
        end
    endtask

    initial begin
        ex_req_t r;
        clk      = 1'b0;
        arst_n_i = 1'b0;
        req      = '0;
        seed     = 32'h170e_0813;
        hung     = 1'b0;
        last_op  = OP_NOP;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // hi and lo come out of reset as zero
        r        = '0;
        r.aluop  = OP_MFHI;
        r.alusel = SEL_MOVE;
        r.wreg   = 1'b1;
        r.wd     = 5'd1;
        issue(r);
        r.aluop  = OP_MFLO;
        r.wd     = 5'd2;
        issue(r);

        for (int i = 0; i < NUM_INSTR && !hung; i++) begin
            r = random_req();
            issue(r);
            last_op = r.aluop;
        end
        @(negedge clk);
        req = '0;
        repeat (2) @(negedge clk);
        #5;

        $display("checks %0d, value errors %0d, stall errors %0d, timeouts %0d",
                 checks, val_errs, stall_errs, hung);
        if (val_errs == 0 && stall_errs == 0 && !hung) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
